// ==== sim.f ====
logic/isaPkg.sv
logic/controlUnit.sv
logic/aluOpDecode.sv
logic/regFileBypass.sv
logic/decode.sv
sim/decodeTb.sv

// ==== sim/decodeTb.sv ====
// directed testbench for the decode stage
// inputs change on the rising edge and outputs are sampled on the falling edge
// a shadow copy of the eight registers follows every write the ISA rules predict
// the register write lands on the edge that applies the next instruction
`timescale 1ns/1ps
`default_nettype none

module decodeTb;
   import isaPkg::*;

   localparam int clkPeriod      = 20;
   localparam int watchdogCycles = 400;   // the tests need about 110 cycles

   logic        clk;
   logic        rstN;
   logic [15:0] instruction;
   logic [15:0] wbData;
   ctrlT        ctrl;
   aluCtlT      aluCtl;
   logic [15:0] imm8;
   logic [15:0] imm11;
   logic [15:0] inA;
   logic [15:0] inB;
   logic [15:0] wrtData;
   logic        err;

   logic [15:0] shadow [8];               // expected register contents
   logic [31:0] rngState;
   int          passChecks;
   int          failChecks;
   int          testStartFails;           // failChecks when the current test began

   decode uut (
      .clk         (clk),
      .rstN        (rstN),
      .instruction (instruction),
      .wbData      (wbData),
      .ctrl        (ctrl),
      .aluCtl      (aluCtl),
      .imm8        (imm8),
      .imm11       (imm11),
      .inA         (inA),
      .inB         (inB),
      .wrtData     (wrtData),
      .err         (err)
   );

   always #(clkPeriod / 2) clk = ~clk;

   // xorshift32
   function automatic logic [15:0] nextRand();
      rngState = rngState ^ (rngState << 13);
      rngState = rngState ^ (rngState >> 17);
      rngState = rngState ^ (rngState << 5);
      return rngState[15:0];
   endfunction

   // sign extend the low bits of v by flipping and subtracting the top bit
   function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
      logic [15:0] top;
      top = 16'(1 << (bits - 1));
      return (v ^ top) - top;
   endfunction

   // instruction builders
   function automatic logic [15:0] rFmt(input logic [2:0] rs, input logic [2:0] rt,
                                        input logic [2:0] rd, input logic [1:0] fn);
      return {opRfmt, rs, rt, rd, fn};
   endfunction

   function automatic logic [15:0] iFmt(input opcodeT op, input logic [2:0] rs,
                                        input logic [2:0] rt, input logic [4:0] imm);
      return {op, rs, rt, imm};
   endfunction

   function automatic logic [15:0] bFmt(input opcodeT op, input logic [2:0] rs,
                                        input logic [7:0] imm);
      return {op, rs, imm};
   endfunction

   function automatic logic [15:0] jFmt(input opcodeT op, input logic [10:0] imm);
      return {op, imm};
   endfunction

   // kind 0..4 is add sub xor andn passB
   function automatic aluCtlT expAlu(input int kind);
      aluCtlT e;
      e = '{aluOp: aluAdd, invA: 1'b0, invB: 1'b0, cin: 1'b0};
      case (kind)
         1: begin
            e.invA = 1'b1;                // B - A
            e.cin  = 1'b1;
         end
         2: e.aluOp = aluXor;
         3: begin
            e.aluOp = aluAndn;
            e.invB  = 1'b1;
         end
         4: e.aluOp = aluPassB;
         default: ;
      endcase
      return e;
   endfunction

   task automatic checkWord(input logic [15:0] got, input logic [15:0] exp, input string msg);
      if (got === exp) passChecks++;
      else begin
         failChecks++;
         $display("FAIL %0t: %s got %h expected %h", $time, msg, got, exp);
      end
   endtask

   task automatic checkCtrl(input ctrlT got, input ctrlT exp, input string msg);
      if (got === exp) passChecks++;
      else begin
         failChecks++;
         $display("FAIL %0t: %s ctrl got %b expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic checkAlu(input aluCtlT got, input aluCtlT exp, input string msg);
      if (got === exp) passChecks++;
      else begin
         failChecks++;
         $display("FAIL %0t: %s aluCtl got %b expected %b", $time, msg, got, exp);
      end
   endtask

   task automatic checkErr(input logic got, input logic exp, input string msg);
      if (got === exp) passChecks++;
      else begin
         failChecks++;
         $display("FAIL %0t: %s err got %b expected %b", $time, msg, got, exp);
      end
   endtask

   // one instruction per cycle with outputs settled by the falling edge
   task automatic apply(input logic [15:0] instr, input logic [15:0] wb);
      @(posedge clk);
      instruction <= instr;
      wbData      <= wb;
      @(negedge clk);
   endtask

   task automatic endTest(input string name);
      int errs;
      errs = failChecks - testStartFails;
      if (errs == 0) $display("%s: ok", name);
      else $display("%s: %0d mismatches", name, errs);
      testStartFails = failChecks;
   endtask

   // NOP never writes but its Rs field still drives read port A
   task automatic readbackAll(input string tag);
      for (int i = 0; i < 8; i++) begin
         apply({opNop, 3'(i), 8'h00}, nextRand());
         checkWord(inA, shadow[i], $sformatf("%s readback R%0d", tag, i));
      end
   endtask

   task automatic resetTest();
      for (int i = 0; i < 8; i++) begin
         // Rd trails Rs so neither read port is bypassed
         apply(rFmt(3'(i), 3'(i), 3'(i + 7), 2'b00), 16'h0000);
         checkWord(inA, 16'h0000, $sformatf("inA of R%0d after reset", i));
         checkWord(inB, 16'h0000, $sformatf("inB of R%0d after reset", i));
         shadow[3'(i + 7)] = 16'h0000;
      end
      endTest("reset");
   endtask

   task automatic writeReadTest();
      logic [15:0] wb;
      logic [2:0]  rs;
      for (int i = 0; i < 8; i++) begin
         wb = nextRand();
         if (i % 2 == 0) begin
            apply(bFmt(opLbi, 3'(i), 8'h00), wb);             // dest Rs, read Rs
            checkWord(inA, wb, $sformatf("LBI bypass R%0d", i));
         end else begin
            rs = 3'(i + 1);
            apply(rFmt(rs, 3'(i), 3'(i), 2'b00), wb);        // dest Rd, Rt bypassed
            checkWord(inA, shadow[rs], $sformatf("R-format read R%0d", rs));
            checkWord(inB, wb, $sformatf("R-format bypass on Rt R%0d", i));
         end
         shadow[i] = wb;
      end
      readbackAll("write");
      wb = nextRand();
      apply(rFmt(3'd5, 3'd0, 3'd5, 2'b10), wb);                // Rs equals Rd
      checkWord(inA, wb, "same-cycle bypass on R5");
      shadow[5] = wb;
      endTest("write and readback");
   endtask

   task automatic immediateTest();
      logic [15:0] r;
      logic [15:0] wb;
      for (int k = 0; k < 8; k++) begin
         r  = nextRand();
         wb = nextRand();
         apply(jFmt(opJ, r[10:0]), wb);
         checkWord(imm11, sext(r & 16'h07ff, 11), "J imm11");
         checkWord(inB, sext(r & 16'h07ff, 11), "J operand B");
         apply(bFmt(opLbi, 3'(k), r[7:0]), wb);
         checkWord(imm8, sext(r & 16'h00ff, 8), "LBI imm8");
         shadow[k] = wb;
         apply(bFmt(opSlbi, 3'(k), r[15:8]), wb);
         checkWord(imm8, r >> 8, "SLBI imm8");                // unsigned byte
         shadow[k] = wb;
         apply(iFmt(opAddi, 3'(k), 3'(7 - k), r[4:0]), wb);
         checkWord(inB, sext(r & 16'h001f, 5), "ADDI imm5");
         shadow[7 - k] = wb;
         apply(iFmt(opXori, 3'(k), 3'(7 - k), r[9:5]), wb);
         checkWord(inB, (r >> 5) & 16'h001f, "XORI imm5");
         shadow[7 - k] = wb;
      end
      endTest("immediates");
   endtask

   task automatic aluCtlTest();
      opcodeT      immOps [4];
      logic [15:0] wb;
      ctrlT        slbiCtrl;
      immOps = '{opAddi, opSubi, opXori, opAndni};
      for (int f = 0; f < 4; f++) begin
         wb = nextRand();
         apply(rFmt(3'd1, 3'd2, 3'd3, 2'(f)), wb);
         checkAlu(aluCtl, expAlu(f), $sformatf("R-format funct %0d", f));
         shadow[3] = wb;
         apply(iFmt(immOps[f], 3'd1, 3'd4, 5'd3), wb);
         checkAlu(aluCtl, expAlu(f), immOps[f].name());
         shadow[4] = wb;
      end
      wb = nextRand();
      apply(bFmt(opLbi, 3'd6, 8'h12), wb);
      checkAlu(aluCtl, expAlu(4), "LBI");
      checkCtrl(ctrl, '0, "LBI");
      shadow[6] = wb;
      slbiCtrl = '0;
      slbiCtrl.slbiSel = 1'b1;
      apply(bFmt(opSlbi, 3'd6, 8'h34), wb);
      checkAlu(aluCtl, expAlu(4), "SLBI");
      checkCtrl(ctrl, slbiCtrl, "SLBI");
      shadow[6] = wb;
      endTest("ALU control");
   endtask

   // apply and expect exactly this ctrl with no err
   task automatic ctrlStep(input logic [15:0] instr, input logic [15:0] wb,
                           input ctrlT exp, input string name);
      apply(instr, wb);
      checkCtrl(ctrl, exp, name);
      checkErr(err, 1'b0, name);
   endtask

   task automatic memCtlTest();
      ctrlT        exp;
      logic [15:0] wb;
      exp = '0;
      exp.memWrt = 1'b1;
      ctrlStep(iFmt(opSt, 3'd1, 3'd2, 5'h1d), nextRand(), exp, "ST");
      checkWord(wrtData, sext(16'h001d, 5), "ST store data");
      wb = nextRand();
      ctrlStep(iFmt(opStu, 3'd2, 3'd5, 5'h04), wb, exp, "STU");
      checkWord(wrtData, shadow[5], "STU store data");
      shadow[2] = wb;                                         // Rs updated
      exp = '0;
      exp.wbDataSel = wbMem;
      wb = nextRand();
      ctrlStep(iFmt(opLd, 3'd0, 3'd3, 5'h02), wb, exp, "LD");
      shadow[3] = wb;
      exp = '0;
      exp.brchSig = brchEqz;
      ctrlStep(bFmt(opBeqz, 3'd1, 8'h10), nextRand(), exp, "BEQZ");
      exp.brchSig = brchNez;
      ctrlStep(bFmt(opBnez, 3'd1, 8'h10), nextRand(), exp, "BNEZ");
      exp = '0;
      exp.immSrc = 1'b1;
      ctrlStep(jFmt(opJ, 11'h123), nextRand(), exp, "J");
      exp.wbDataSel = wbPcPlus2;                              // link
      wb = nextRand();
      ctrlStep(jFmt(opJal, 11'h456), wb, exp, "JAL");
      shadow[7] = wb;
      exp = '0;
      exp.aluJmp = 1'b1;
      ctrlStep(bFmt(opJr, 3'd4, 8'h02), nextRand(), exp, "JR");
      exp = '0;
      exp.createDump = 1'b1;
      ctrlStep(jFmt(opHalt, 11'h000), nextRand(), exp, "HALT");
      ctrlStep(jFmt(opNop, 11'h000), nextRand(), '0, "NOP");
      readbackAll("STU and JAL");                             // R2 and R7 among them
      endTest("memory branch jump");
   endtask

   task automatic illegalTest();
      apply({5'b00010, 11'h5a5}, nextRand());
      checkErr(err, 1'b1, "opcode 00010");
      apply({5'b11111, 11'h7ff}, nextRand());
      checkErr(err, 1'b1, "opcode 11111");
      readbackAll("illegal");                                 // shadow untouched
      endTest("illegal opcode");
   endtask

   initial begin
      #(watchdogCycles * clkPeriod);
      $display("timeout: the tests did not finish within %0d clock periods", watchdogCycles);
      $display("Test failed");
      $finish;
   end

   initial begin
      clk            = 1'b0;
      rstN           = 1'b0;
      instruction    = {opNop, 11'h000};
      wbData         = 16'h0000;
      rngState       = 32'ha16c967a;
      passChecks     = 0;
      failChecks     = 0;
      testStartFails = 0;
      for (int i = 0; i < 8; i++) begin
         shadow[i] = 16'h0000;
      end
      repeat (5) @(posedge clk);
      rstN <= 1'b1;
      resetTest();
      writeReadTest();
      immediateTest();
      aluCtlTest();
      memCtlTest();
      illegalTest();
      $display("checks passed %0d, failed %0d", passChecks, failChecks);
      if (failChecks == 0) begin
         $display("Test completed successfully");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/decode.sv ====
// decode stage top of the 16-bit teaching processor
// every output is combinational from instruction and wbData
// only the register write waits for the rising clk edge
// err flags an illegal opcode and nothing else
`timescale 1ns/1ps
`default_nettype none

module decode (
   input  logic           clk,
   input  logic           rstN,
   input  logic [15:0]    instruction,
   input  logic [15:0]    wbData,      // result from writeback
   output isaPkg::ctrlT   ctrl,
   output isaPkg::aluCtlT aluCtl,
   output logic [15:0]    imm8,
   output logic [15:0]    imm11,
   output logic [15:0]    inA,
   output logic [15:0]    inB,
   output logic [15:0]    wrtData,     // memory store data
   output logic           err
);
   import isaPkg::*;

   aluSelT      aluSel;
   bSrcT        bSrc;
   destSelT     destSel;
   logic        zeroSel;
   logic        stuSel;
   logic        regWrt;
   logic [2:0]  writeSel;
   logic [15:0] imm5;
   logic [15:0] regB;                 // Rt register value

   controlUnit ctrlUnit (
      .instruction (instruction),
      .ctrl        (ctrl),
      .aluSel      (aluSel),
      .bSrc        (bSrc),
      .destSel     (destSel),
      .zeroSel     (zeroSel),
      .stuSel      (stuSel),
      .regWrt      (regWrt),
      .err         (err)
   );

   aluOpDecode aluDec (
      .aluSel (aluSel),
      .funct  (instruction[1:0]),
      .aluCtl (aluCtl)
   );

   // immediates
   assign imm5  = zeroSel ? {11'b0, instruction[4:0]} : {{11{instruction[4]}}, instruction[4:0]};
   assign imm8  = zeroSel ? {8'b0, instruction[7:0]} : {{8{instruction[7]}}, instruction[7:0]};
   assign imm11 = {{5{instruction[10]}}, instruction[10:0]};   // always signed

   // destination register
   always_comb begin
      case (destSel)
         destRs:  writeSel = instruction[10:8];
         destRt:  writeSel = instruction[7:5];
         destRd:  writeSel = instruction[4:2];
         default: writeSel = 3'd7;    // JAL link register
      endcase
   end

   regFileBypass regFile (
      .clk       (clk),
      .rstN      (rstN),
      .readASel  (instruction[10:8]),
      .readBSel  (instruction[7:5]),
      .writeSel  (writeSel),
      .writeData (wbData),
      .writeEn   (regWrt),
      .readA     (inA),
      .readB     (regB)
   );

   // operand B
   always_comb begin
      case (bSrc)
         bReg:    inB = regB;
         bImm5:   inB = imm5;
         bImm11:  inB = imm11;
         default: inB = '0;
      endcase
   end

   assign wrtData = stuSel ? regB : inB;   // STU stores Rt

endmodule

`default_nettype wire

// ==== logic/regFileBypass.sv ====
// eight 16-bit registers with two read ports and one write port
// a read of the register being written returns the write data in the same cycle
// rstN clears every register asynchronously
`timescale 1ns/1ps
`default_nettype none

module regFileBypass (
   input  logic        clk,
   input  logic        rstN,
   input  logic [2:0]  readASel,
   input  logic [2:0]  readBSel,
   input  logic [2:0]  writeSel,
   input  logic [15:0] writeData,
   input  logic        writeEn,
   output logic [15:0] readA,
   output logic [15:0] readB
);
   localparam int regCount = 8;     // fixed by the ISA

   logic [15:0] regs [regCount];
   logic        bypassA;
   logic        bypassB;

   // write port
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

   // write-through so a consumer in the same cycle sees the new value
   assign bypassA = writeEn && (readASel == writeSel);
   assign bypassB = writeEn && (readBSel == writeSel);

   assign readA = bypassA ? writeData : regs[readASel];
   assign readB = bypassB ? writeData : regs[readBSel];

endmodule

`default_nettype wire

// ==== logic/aluOpDecode.sv ====
// turns the ALU class from the opcode decoder into ALU control bits
// R-format funct codes 00 01 10 11 select add sub xor andn
// subtract computes B - A by inverting A with carry in set
`timescale 1ns/1ps
`default_nettype none

module aluOpDecode (
   input  isaPkg::aluSelT aluSel,
   input  logic [1:0]     funct,     // instruction[1:0]
   output isaPkg::aluCtlT aluCtl
);
   import isaPkg::*;

   aluSelT aluClass;                 // class after funct resolution

   always_comb begin
      aluClass = aluSel;
      if (aluSel == selFunct) begin
         case (funct)
            2'b00:   aluClass = selAdd;
            2'b01:   aluClass = selSub;
            2'b10:   aluClass = selXor;
            default: aluClass = selAndn;
         endcase
      end
   end

   // expand the class into op and operand conditioning
   always_comb begin
      aluCtl = '{aluOp: aluAdd, invA: 1'b0, invB: 1'b0, cin: 1'b0};
      case (aluClass)
         selSub: begin
            aluCtl.invA = 1'b1;
            aluCtl.cin  = 1'b1;      // two's complement of A
         end
         selXor:   aluCtl.aluOp = aluXor;
         selAndn: begin
            aluCtl.aluOp = aluAndn;
            aluCtl.invB  = 1'b1;     // A and not B
         end
         selPassB: aluCtl.aluOp = aluPassB;
         default: ;                  // plain add
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/controlUnit.sv ====
// main opcode decoder of the decode stage
// purely combinational decode of instruction[15:11]
// unlisted opcodes raise err and never write the register file
`timescale 1ns/1ps
`default_nettype none

module controlUnit (
   input  logic [15:0]     instruction,
   output isaPkg::ctrlT    ctrl,
   output isaPkg::aluSelT  aluSel,
   output isaPkg::bSrcT    bSrc,
   output isaPkg::destSelT destSel,
   output logic            zeroSel,    // zero extend imm5 and imm8
   output logic            stuSel,     // store data comes from Rt register
   output logic            regWrt,
   output logic            err
);
   import isaPkg::*;

   opcodeT opcode;

   assign opcode = opcodeT'(instruction[15:11]);

   // one table for every opcode
   // defaults describe a NOP and each entry only overrides what differs
   always_comb begin
      ctrl    = ctrlNone;
      aluSel  = selAdd;
      bSrc    = bReg;
      destSel = destRs;
      zeroSel = 1'b0;
      stuSel  = 1'b0;
      regWrt  = 1'b0;
      err     = 1'b0;

      case (opcode)
         opHalt: ctrl.createDump = 1'b1;
         opNop: ;                          // all defaults

         // I-format 1 arithmetic, Rt gets Rs op imm5
         opAddi: begin
            destSel = destRt;
            bSrc    = bImm5;
            regWrt  = 1'b1;
         end
         opSubi: begin
            aluSel  = selSub;              // imm5 - Rs
            destSel = destRt;
            bSrc    = bImm5;
            regWrt  = 1'b1;
         end
         opXori: begin
            aluSel  = selXor;
            destSel = destRt;
            bSrc    = bImm5;
            zeroSel = 1'b1;                // logical ops take unsigned imm
            regWrt  = 1'b1;
         end
         opAndni: begin
            aluSel  = selAndn;
            destSel = destRt;
            bSrc    = bImm5;
            zeroSel = 1'b1;
            regWrt  = 1'b1;
         end

         // memory ops address with Rs + imm5
         opSt: begin
            ctrl.memWrt = 1'b1;
            bSrc        = bImm5;
         end
         opLd: begin
            ctrl.wbDataSel = wbMem;
            bSrc           = bImm5;
            destSel        = destRt;
            regWrt         = 1'b1;
         end
         opStu: begin
            ctrl.memWrt = 1'b1;
            stuSel      = 1'b1;
            bSrc        = bImm5;
            destSel     = destRs;          // updated address back to Rs
            regWrt      = 1'b1;
         end

         // byte immediates go through the ALU as operand B
         opLbi: begin
            aluSel  = selPassB;
            destSel = destRs;
            regWrt  = 1'b1;
         end
         opSlbi: begin
            ctrl.slbiSel = 1'b1;
            aluSel       = selPassB;
            zeroSel      = 1'b1;
            destSel      = destRs;
            regWrt       = 1'b1;
         end

         opRfmt: begin
            aluSel  = selFunct;
            bSrc    = bReg;
            destSel = destRd;
            regWrt  = 1'b1;
         end

         opBeqz: ctrl.brchSig = brchEqz;
         opBnez: ctrl.brchSig = brchNez;

         opJ: begin
            ctrl.immSrc = 1'b1;
            bSrc        = bImm11;
         end
         opJal: begin
            ctrl.immSrc    = 1'b1;
            ctrl.wbDataSel = wbPcPlus2;    // link address
            bSrc           = bImm11;
            destSel        = destR7;
            regWrt         = 1'b1;
         end
         opJr: ctrl.aluJmp = 1'b1;         // target is Rs + imm8

         default: begin
            err    = 1'b1;
            regWrt = 1'b0;                 // illegal op leaves state alone
         end
      endcase
   end

endmodule

`default_nettype wire

// ==== logic/isaPkg.sv ====
// types shared by the decode stage RTL and its testbench
// opcode values follow the 16-bit teaching ISA and cover only the supported subset
// ctrlT and aluCtlT are the bundles seen on the decode outputs
// enum value zero is always the inactive choice so a NOP decodes to all zeros
`default_nettype none

package isaPkg;

   // major opcode held in instruction[15:11]
   typedef enum logic [4:0] {
      opHalt  = 5'b00000,
      opNop   = 5'b00001,
      opJ     = 5'b00100,
      opJr    = 5'b00101,
      opJal   = 5'b00110,
      opAddi  = 5'b01000,
      opSubi  = 5'b01001,
      opXori  = 5'b01010,
      opAndni = 5'b01011,
      opBeqz  = 5'b01100,
      opBnez  = 5'b01101,
      opSt    = 5'b10000,
      opLd    = 5'b10001,
      opSlbi  = 5'b10010,
      opStu   = 5'b10011,
      opLbi   = 5'b11000,
      opRfmt  = 5'b11011    // add/sub/xor/andn picked by funct bits
   } opcodeT;

   // ALU class as seen by the opcode decoder
   typedef enum logic [2:0] {
      selAdd   = 3'd0,
      selSub   = 3'd1,
      selXor   = 3'd2,
      selAndn  = 3'd3,
      selFunct = 3'd4,      // resolve from instruction[1:0]
      selPassB = 3'd5       // operand B straight through
   } aluSelT;

   // operation actually performed by the ALU
   typedef enum logic [1:0] {
      aluAdd   = 2'd0,
      aluXor   = 2'd1,
      aluAndn  = 2'd2,
      aluPassB = 2'd3
   } aluOpT;

   // sub is add with ~A and carry in, giving B - A
   typedef struct packed {
      aluOpT aluOp;
      logic  invA;
      logic  invB;
      logic  cin;
   } aluCtlT;

   typedef enum logic [1:0] {bReg, bImm5, bImm11, bZero} bSrcT;       // operand B source

   typedef enum logic [1:0] {destRs, destRt, destRd, destR7} destSelT; // write register

   typedef enum logic [1:0] {wbAlu, wbMem, wbPcPlus2} wbSelT;         // writeback source

   typedef enum logic [1:0] {brchNone, brchEqz, brchNez} brchT;

   // control bundle leaving the decode stage
   typedef struct packed {
      logic  aluJmp;        // JR target comes from the ALU
      logic  slbiSel;       // shift Rs left by 8 before the or
      logic  createDump;    // HALT
      logic  memWrt;
      brchT  brchSig;
      wbSelT wbDataSel;
      logic  immSrc;        // PC adds imm11 instead of the branch offset
   } ctrlT;

   localparam ctrlT ctrlNone = '0;  // every control inactive

endpackage

`default_nettype wire
